// ==== rtl/mouse_link_pkg.sv ====
// Shared types, tag codes and serial timing constants for the mouse position link.
package mouse_link_pkg;

  typedef enum logic [2:0] {
    OP_NOP    = 3'b000,
    OP_SEND_Y = 3'b110,
    OP_SEND_X = 3'b111
  } opcode_t;

  typedef enum logic [1:0] {
    CTL_WAIT,
    CTL_SEND_LO,
    CTL_SEND_HI
  } ctl_state_t;

  // Tags sit in the low three bits of each reply byte.
  localparam logic [2:0] TAG_X_LO = 3'b001;
  localparam logic [2:0] TAG_X_HI = 3'b010;
  localparam logic [2:0] TAG_Y_LO = 3'b011;
  localparam logic [2:0] TAG_Y_HI = 3'b100;

  localparam int POS_W   = 12;
  localparam int POS_MAX = 1023; // Ten bit coordinate range.

  localparam int BAUD_DIV   = 8; // Cycles per serial bit.
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(BAUD_DIV - 1);
  // First wait is half a bit, less the two sync stages of the receiver.
  localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(BAUD_DIV / 2 - 2);

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

// ==== rtl/uart_rx.sv ====
// Serial receiver that turns 8N1 frames on the rx line into command byte strobes.
`timescale 1ns/1ns

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  typedef enum logic {RX_IDLE, RX_SHIFT} rx_state_t;

  rx_state_t                             state;
  logic                                  rx_meta;
  logic                                  rx_sync;
  logic [mouse_link_pkg::BAUD_CNT_W-1:0] baud_cnt;
  logic [3:0]                            bit_cnt; // 0 start, 1..8 data, 9 stop.
  logic                                  sample;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign sample = (state == RX_SHIFT) && (baud_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (!rx_sync) begin // Start edge.
            state    <= RX_SHIFT;
            baud_cnt <= mouse_link_pkg::BAUD_HALF;
            bit_cnt  <= '0;
          end
        end
        RX_SHIFT: begin
          if (!sample) begin
            baud_cnt <= baud_cnt - 1'b1;
          end else begin
            baud_cnt <= mouse_link_pkg::BAUD_LAST;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd0 && rx_sync) begin
              state <= RX_IDLE; // Glitch, start bit gone at mid-bit.
            end else if (bit_cnt == 4'd9) begin
              state    <= RX_IDLE;
              rx_valid <= rx_sync; // Low stop bit drops the frame.
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first.
  always_ff @(posedge clk) begin
    if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
  end

endmodule

// ==== rtl/mouse_ctl.sv ====
// Control FSM that decodes command opcodes and queues the tagged coordinate bytes.
`timescale 1ns/1ns

module mouse_ctl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [7:0]                       rx_byte,
  input  logic                             rx_valid,
  input  logic [mouse_link_pkg::POS_W-1:0] xpos,
  input  logic [mouse_link_pkg::POS_W-1:0] ypos,
  input  logic                             full,
  output logic                             push,
  output logic [7:0]                       push_byte
);

  mouse_link_pkg::ctl_state_t       state;
  mouse_link_pkg::ctl_state_t       state_nxt;
  mouse_link_pkg::opcode_t          opcode;
  logic                             cmd_send;
  logic                             cmd_y;
  logic [mouse_link_pkg::POS_W-1:0] raw_pos;
  logic [9:0]                       clamped;
  logic [9:0]                       pos;  // Latched at command acceptance.
  logic                             pos_y;
  logic [2:0]                       lo_tag;
  logic [2:0]                       hi_tag;

  assign opcode = mouse_link_pkg::opcode_t'(rx_byte[2:0]);

  always_comb begin
    cmd_send = 1'b1;
    cmd_y    = 1'b0;
    case (opcode)
      mouse_link_pkg::OP_SEND_X: cmd_y = 1'b0;
      mouse_link_pkg::OP_SEND_Y: cmd_y = 1'b1;
      mouse_link_pkg::OP_NOP:    cmd_send = 1'b0;
      default:                   cmd_send = 1'b0; // Unused codes act as a NOP.
    endcase
  end

  assign raw_pos = cmd_y ? ypos : xpos;
  // 1023 is all ten bits set.
  assign clamped = (raw_pos > mouse_link_pkg::POS_MAX) ? '1 : raw_pos[9:0];

  always_comb begin
    state_nxt = state;
    case (state)
      mouse_link_pkg::CTL_WAIT: begin
        if (rx_valid && cmd_send) begin
          state_nxt = mouse_link_pkg::CTL_SEND_LO;
        end
      end
      mouse_link_pkg::CTL_SEND_LO: begin
        if (!full) begin
          state_nxt = mouse_link_pkg::CTL_SEND_HI;
        end
      end
      mouse_link_pkg::CTL_SEND_HI: begin
        if (!full) begin
          state_nxt = mouse_link_pkg::CTL_WAIT;
        end
      end
      default: state_nxt = mouse_link_pkg::CTL_WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mouse_link_pkg::CTL_WAIT;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (state == mouse_link_pkg::CTL_WAIT && rx_valid && cmd_send) begin
      pos   <= clamped;
      pos_y <= cmd_y;
    end
  end

  assign lo_tag = pos_y ? mouse_link_pkg::TAG_Y_LO : mouse_link_pkg::TAG_X_LO;
  assign hi_tag = pos_y ? mouse_link_pkg::TAG_Y_HI : mouse_link_pkg::TAG_X_HI;

  // Both send states push once the queue has room.
  assign push = ((state == mouse_link_pkg::CTL_SEND_LO) ||
                 (state == mouse_link_pkg::CTL_SEND_HI)) && !full;

  assign push_byte = (state == mouse_link_pkg::CTL_SEND_HI) ? {pos[9:5], hi_tag}
                                                            : {pos[4:0], lo_tag};

endmodule

// ==== rtl/tx_fifo.sv ====
// Small circular byte queue between the control FSM and the transmitter.
`timescale 1ns/1ns

module tx_fifo (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic [7:0] push_byte,
  input  logic       pop,
  output logic [7:0] pop_byte,
  output logic       full,
  output logic       empty
);

  logic [7:0]                            mem [mouse_link_pkg::FIFO_DEPTH];
  logic [mouse_link_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [mouse_link_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [mouse_link_pkg::FIFO_PTR_W:0]   count;
  logic                                  do_push;
  logic                                  do_pop;

  assign full    = count[mouse_link_pkg::FIFO_PTR_W]; // Depth is a power of two.
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap on their own.
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_byte = mem[rd_ptr];

endmodule

// ==== rtl/uart_tx.sv ====
// Serial transmitter that pops queued bytes and shifts them out as 8N1 frames.
`timescale 1ns/1ns

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       empty,
  input  logic [7:0] pop_byte,
  output logic       pop,
  output logic       tx
);

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

  tx_state_t                             state;
  logic [mouse_link_pkg::BAUD_CNT_W-1:0] baud_cnt;
  logic [3:0]                            bit_cnt;
  logic [9:0]                            frame;   // Stop, data, start.

  assign pop = (state == TX_IDLE) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (pop) begin
            state    <= TX_SHIFT;
            baud_cnt <= mouse_link_pkg::BAUD_LAST;
            bit_cnt  <= '0;
          end
        end
        TX_SHIFT: begin
          if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
          end else if (bit_cnt == 4'd9) begin
            state <= TX_IDLE; // Stop bit done.
          end else begin
            baud_cnt <= mouse_link_pkg::BAUD_LAST;
            bit_cnt  <= bit_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      frame <= {1'b1, pop_byte, 1'b0};
    end else if (state == TX_SHIFT && baud_cnt == '0) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

  assign tx = (state == TX_SHIFT) ? frame[0] : 1'b1;

endmodule

// ==== rtl/mouse_link.sv ====
// Mouse position link top level joining receiver, control, queue and transmitter.
`timescale 1ns/1ns

module mouse_link (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rx,
  input  logic [mouse_link_pkg::POS_W-1:0] xpos,
  input  logic [mouse_link_pkg::POS_W-1:0] ypos,
  output logic                             tx
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       push;
  logic [7:0] push_byte;
  logic       full;
  logic       pop;
  logic [7:0] pop_byte;
  logic       empty;

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  mouse_ctl u_mouse_ctl (
    .clk       (clk),
    .rst       (rst),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .xpos      (xpos),
    .ypos      (ypos),
    .full      (full),
    .push      (push),
    .push_byte (push_byte)
  );

  tx_fifo u_tx_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_byte (push_byte),
    .pop       (pop),
    .pop_byte  (pop_byte),
    .full      (full),
    .empty     (empty)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .rst      (rst),
    .empty    (empty),
    .pop_byte (pop_byte),
    .pop      (pop),
    .tx       (tx)
  );

endmodule

// ==== sim/tb_clock.sv ====
// Testbench clock source with an 8 ns period.
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 4;

  initial clk = 1'b0;

  always #HALF_PERIOD clk = ~clk;

endmodule

// ==== sim/mouse_link_assertions.sv ====
// Bound checker for the queue handshake and the serial lines.
`timescale 1ns/1ns

module mouse_link_assertions (
  input logic clk,
  input logic rst,
  input logic push,
  input logic full,
  input logic rx_valid,
  input logic tx,
  input logic tx_busy  // TX_IDLE is the zero state.
);

  int unsigned error_count = 0;

  no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else begin
      error_count++;
      $error("push while the queue is full");
    end

  tx_high_when_idle: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
    else begin
      error_count++;
      $error("tx low while the transmitter is idle");
    end

  rx_valid_single: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else begin
      error_count++;
      $error("rx_valid high for two cycles");
    end

endmodule

bind mouse_link mouse_link_assertions u_assertions (
  .clk      (clk),
  .rst      (rst),
  .push     (push),
  .full     (full),
  .rx_valid (rx_valid),
  .tx       (tx),
  .tx_busy  (u_uart_tx.state)
);

// ==== sim/mouse_link_tb.sv ====
// Testbench for the mouse position link, replaying serial commands from the cases file.
`timescale 1ns/1ns

module mouse_link_tb;

  localparam int POS_W     = mouse_link_pkg::POS_W;
  localparam int BIT_CYC   = mouse_link_pkg::BAUD_DIV;
  localparam int MAX_CASES = 32;
  localparam int CASE_BITS = 10 + 2 * 10 + 30 + 10;
  localparam int WAIT_CYC  = 40 * BIT_CYC;  // Longest wait for a start bit.
  localparam int QUIET_CYC = 30 * BIT_CYC;
  localparam int RESET_CYC = 10;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic             clk;
  logic             rst;
  logic             rx;
  logic [POS_W-1:0] xpos;
  logic [POS_W-1:0] ypos;
  logic             tx;

  string            name [MAX_CASES];
  int               ncmd [MAX_CASES];
  logic [7:0]       cmd [MAX_CASES][2];
  logic [POS_W-1:0] xval [MAX_CASES][2];
  logic [POS_W-1:0] yval [MAX_CASES][2];
  int               nexp [MAX_CASES];
  logic [7:0]       exp_byte [MAX_CASES][4];
  int               num_cases;
  int               errors;
  int               received;
  int               pass_count;
  int               fail_count;
  int               cycles = 0;
  int               cycle_limit = 0;
  logic [31:0]      lfsr = 32'hf498;
  logic             reply_started;

  tb_clock u_tb_clock (.clk(clk));

  mouse_link u_mouse_link (.clk(clk), .rst(rst), .rx(rx), .xpos(xpos), .ypos(ypos), .tx(tx));

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, a command or reply never finished", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
  endfunction

  function automatic logic [POS_W-1:0] random_pos();
    logic [POS_W-1:0] value;
    for (int i = 0; i < POS_W; i++) begin
      value[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    return value;
  endfunction

  task automatic check_byte(input string test, input mouse_link_pkg::opcode_t op,
                            input int index, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s byte %0d (opcode %03b): expected 8'h%02h, actual 8'h%02h",
               test, index, op, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string test, input int expected, input int actual);
    if (actual != expected) begin
      $display("[FAIL] %s frame count: expected %0d, actual %0d", test, expected, actual);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (BIT_CYC) next_cycle();
    end
  endtask

  task automatic drive_commands(input int c);
    for (int k = 0; k < ncmd[c]; k++) begin
      while (k > 0 && !reply_started) next_cycle(); // Next command once the reply runs.
      next_cycle();
      xpos = xval[c][k];
      ypos = yval[c][k];
      send_byte(cmd[c][k]);
      xpos = random_pos(); // The reply must keep the latched value.
      ypos = random_pos();
    end
  endtask

  // Samples tx on falling edges, near the middle of each bit.
  task automatic receive_byte(output logic [7:0] value, output bit ok);
    int waited;
    value = '0;
    ok = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx !== 1'b0 && waited < WAIT_CYC);
    if (tx !== 1'b0) return;
    reply_started = 1'b1;
    repeat (BIT_CYC / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYC) @(negedge clk);
      value[i] = tx;
    end
    repeat (BIT_CYC) @(negedge clk);
    ok = (tx === 1'b1);
  endtask

  task automatic collect_reply(input int c);
    logic [7:0] value;
    bit         ok;
    for (int i = 0; i < nexp[c]; i++) begin
      receive_byte(value, ok);
      if (!ok) begin
        $display("%s: reply byte %0d never arrived or had a low stop bit", name[c], i);
        errors++;
        break;
      end
      received++;
      check_byte(name[c], mouse_link_pkg::opcode_t'(cmd[c][i / 2][2:0]), i,
                 exp_byte[c][i], value);
    end
  endtask

  task automatic run_case(input int c);
    int   extra;
    logic prev;
    errors = 0;
    received = 0;
    reply_started = 1'b0;
    fork
      drive_commands(c);
      collect_reply(c);
    join
    extra = 0;
    prev = tx;
    repeat (QUIET_CYC) begin
      @(negedge clk);
      if (prev === 1'b1 && tx === 1'b0) extra++; // Unexpected start bit.
      prev = tx;
    end
    check_count(name[c], nexp[c], received + extra);
    if (errors == 0) begin
      pass_count++;
      $display("case %s ok", name[c]);
    end else begin
      fail_count++;
      $display("case %s had %0d errors", name[c], errors);
    end
  endtask

  task automatic load_cases(output bit ok);
    int         fd;
    int         fields;
    string      line;
    string      test;
    int         n_cmd, x0, y0, x1, y1, n_bytes;
    logic [7:0] c0, c1, e0, e1, e2, e3;
    ok = 1'b0;
    num_cases = 0;
    fd = $fopen("sim/mouse_link_cases.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%s %d %h %d %d %h %d %d %d %h %h %h %h", test, n_cmd, c0,
                       x0, y0, c1, x1, y1, n_bytes, e0, e1, e2, e3);
      if (fields != 13 || num_cases == MAX_CASES || n_cmd < 1 || n_cmd > 2 || n_bytes > 4) begin
        $fclose(fd);
        return;
      end
      name[num_cases] = test;
      ncmd[num_cases] = n_cmd;
      nexp[num_cases] = n_bytes;
      cmd[num_cases] = '{c0, c1};
      xval[num_cases] = '{x0[POS_W-1:0], x1[POS_W-1:0]};
      yval[num_cases] = '{y0[POS_W-1:0], y1[POS_W-1:0]};
      exp_byte[num_cases] = '{e0, e1, e2, e3};
      num_cases++;
    end
    $fclose(fd);
    ok = (num_cases > 0);
  endtask

  initial begin
    bit cases_ok;
    rst = 1'b1;
    rx = 1'b1;
    xpos = '0;
    ypos = '0;
    pass_count = 0;
    fail_count = 0;
    reply_started = 1'b0;
    load_cases(cases_ok);
    if (!cases_ok) begin
      $display("Could not read a valid case list from sim/mouse_link_cases.txt");
      $display("test failed");
      $finish;
    end else begin
      cycle_limit = num_cases * CASE_BITS * BIT_CYC + RESET_CYC;
      repeat (RESET_CYC) next_cycle();
      rst = 1'b0;
      for (int c = 0; c < num_cases; c++) begin
        run_case(c);
      end
      $display("cases passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && u_mouse_link.u_assertions.error_count == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

// ==== sim/mouse_link_cases.txt ====
# name ncmd cmd0 x0 y0 cmd1 x1 y1 nbytes byte0 byte1 byte2 byte3
# Commands and bytes in hex, coordinates in decimal, unused columns are zero.
send_x      1 07  100  700 00    0    0 2 21 1a 00 00
send_y      1 06  100  700 00    0    0 2 e3 ac 00 00
zero_y      1 06  100    0 00    0    0 2 03 04 00 00
clamp_x     1 07 3000    5 00    0    0 2 f9 fa 00 00
clamp_y     1 06    5 4095 00    0    0 2 fb fc 00 00
max_x       1 07 1023    0 00    0    0 2 f9 fa 00 00
upper_bits  1 af    0  700 00    0    0 2 01 02 00 00
nop         1 00  100  700 00    0    0 0 00 00 00 00
nop_upper   1 f8  100  700 00    0    0 0 00 00 00 00
unused_op   1 03  100  700 00    0    0 0 00 00 00 00
seq_x_y     2 07  517  900 06 3000   42 4 29 82 53 0c
seq_y_x     2 06    9  700 07  100 2000 4 e3 ac 21 1a

// ==== mouse_link.f ====
rtl/mouse_link_pkg.sv
rtl/uart_rx.sv
rtl/mouse_ctl.sv
rtl/tx_fifo.sv
rtl/uart_tx.sv
rtl/mouse_link.sv
sim/tb_clock.sv
sim/mouse_link_assertions.sv
sim/mouse_link_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = mouse_link_tb
FILELIST = mouse_link.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
